//--- Bender.yml
package:
  name: rv32i_pipeline

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/reg_file.sv
      - hdl/decode_ctrl.sv
      - hdl/exec_unit.sv
      - hdl/mem_wb_unit.sv
      - hdl/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_checker.sv
      - sim/cpu_assert.sv
      - sim/cpu_tb.sv

//--- hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen    = 32;
    localparam int reg_num = 32;
    localparam int reg_aw  = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [6:0] f7_alt     = 7'b0100000; // Selects SUB

    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        pc_plus4, pc_branch, pc_jal, pc_jalr
    } pc_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    // One instruction word, six views
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

endpackage

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [cpu_pkg::xlen-1:0] imem_addr,
    input  logic [cpu_pkg::xlen-1:0] imem_data,
    input  logic                     imem_ready,
    output logic [cpu_pkg::xlen-1:0] dmem_addr,
    output logic [cpu_pkg::xlen-1:0] dmem_write_data,
    output logic                     dmem_read,
    output logic                     dmem_write,
    input  logic [cpu_pkg::xlen-1:0] dmem_read_data,
    input  logic                     dmem_ready,
    output logic [cpu_pkg::xlen-1:0] debug_pc,
    output logic [cpu_pkg::xlen-1:0] debug_inst,
    output logic                     pipeline_stall
);
    import cpu_pkg::*;

    // IF/ID
    logic [xlen-1:0]   id_pc;
    inst_u             id_inst;
    logic              id_valid;

    // Decode to fetch
    logic              freeze;
    logic              hold;
    logic              flush;
    pc_sel_e           pc_sel;
    logic [xlen-1:0]   target;

    // Register file read side
    logic [reg_aw-1:0] rs1;
    logic [reg_aw-1:0] rs2;
    logic [xlen-1:0]   rs1_data;
    logic [xlen-1:0]   rs2_data;

    // Decode to execute
    logic [xlen-1:0]   op_a;
    logic [xlen-1:0]   op_b;
    logic [xlen-1:0]   store_data;
    alu_op_e           alu_op;
    logic [reg_aw-1:0] rd;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              issue;

    // Later stages, also the forwarding sources
    logic [xlen-1:0]   ex_result;
    logic [reg_aw-1:0] ex_rd;
    logic              ex_reg_write;
    logic              ex_is_load;
    logic [xlen-1:0]   mm_result;
    logic [xlen-1:0]   mm_store_data;
    logic [reg_aw-1:0] mm_rd;
    logic              mm_reg_write;
    logic              mm_mem_read;
    logic              mm_mem_write;
    logic              mm_is_load;
    logic              mem_busy;
    logic [xlen-1:0]   wb_data;
    logic [reg_aw-1:0] wb_rd;
    logic              wb_reg_write;

    assign debug_pc   = id_pc;
    assign debug_inst = id_inst;

    fetch_unit u_fetch (
        .clk, .rst_n, .freeze, .hold, .flush, .pc_sel, .target,
        .imem_addr, .imem_data, .imem_ready, .id_pc, .id_inst, .id_valid
    );

    decode_ctrl u_decode (
        .id_pc, .id_inst, .id_valid, .rs1, .rs2, .rs1_data, .rs2_data,
        .ex_result, .ex_rd, .ex_reg_write, .ex_is_load,
        .mm_result, .mm_rd, .mm_reg_write, .mm_is_load,
        .wb_data, .wb_rd, .wb_reg_write, .mem_busy,
        .op_a, .op_b, .store_data, .alu_op, .rd, .reg_write, .mem_read, .mem_write, .issue,
        .pc_sel, .target, .flush, .hold, .freeze, .pipeline_stall
    );

    reg_file u_regs (
        .clk, .rst_n, .rs1, .rs2, .rs1_data, .rs2_data,
        .we    (wb_reg_write),
        .rd    (wb_rd),
        .wdata (wb_data)
    );

    exec_unit u_exec (
        .clk, .rst_n, .freeze, .issue, .op_a, .op_b, .store_data, .alu_op,
        .rd, .reg_write, .mem_read, .mem_write,
        .ex_result, .ex_rd, .ex_reg_write, .ex_is_load,
        .mm_result, .mm_store_data, .mm_rd, .mm_reg_write, .mm_mem_read, .mm_mem_write
    );

    mem_wb_unit u_mem_wb (
        .clk, .rst_n, .mm_result, .mm_store_data, .mm_rd, .mm_reg_write,
        .mm_mem_read, .mm_mem_write,
        .dmem_addr, .dmem_write_data, .dmem_read, .dmem_write, .dmem_read_data, .dmem_ready,
        .mem_busy, .mm_is_load, .wb_data, .wb_rd, .wb_reg_write
    );

endmodule

//--- hdl/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
    input  logic [cpu_pkg::xlen-1:0]   id_pc,
    input  cpu_pkg::inst_u             id_inst,
    input  logic                       id_valid,
    output logic [cpu_pkg::reg_aw-1:0] rs1,
    output logic [cpu_pkg::reg_aw-1:0] rs2,
    input  logic [cpu_pkg::xlen-1:0]   rs1_data,
    input  logic [cpu_pkg::xlen-1:0]   rs2_data,
    input  logic [cpu_pkg::xlen-1:0]   ex_result,
    input  logic [cpu_pkg::reg_aw-1:0] ex_rd,
    input  logic                       ex_reg_write,
    input  logic                       ex_is_load,
    input  logic [cpu_pkg::xlen-1:0]   mm_result,
    input  logic [cpu_pkg::reg_aw-1:0] mm_rd,
    input  logic                       mm_reg_write,
    input  logic                       mm_is_load,
    input  logic [cpu_pkg::xlen-1:0]   wb_data,
    input  logic [cpu_pkg::reg_aw-1:0] wb_rd,
    input  logic                       wb_reg_write,
    input  logic                       mem_busy,
    output logic [cpu_pkg::xlen-1:0]   op_a,
    output logic [cpu_pkg::xlen-1:0]   op_b,
    output logic [cpu_pkg::xlen-1:0]   store_data,
    output cpu_pkg::alu_op_e           alu_op,
    output logic [cpu_pkg::reg_aw-1:0] rd,
    output logic                       reg_write,
    output logic                       mem_read,
    output logic                       mem_write,
    output logic                       issue,
    output cpu_pkg::pc_sel_e           pc_sel,
    output logic [cpu_pkg::xlen-1:0]   target,
    output logic                       flush,
    output logic                       hold,
    output logic                       freeze,
    output logic                       pipeline_stall
);
    import cpu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] link;
    logic            use_rs1;
    logic            use_rs2;
    logic            taken;
    logic            redirect;
    pc_sel_e         jump_sel;

    // Youngest producer wins
    function automatic logic [xlen-1:0] forward(input logic [reg_aw-1:0] src,
                                                input logic [xlen-1:0]   rf_value);
        if (src == '0) begin
            return '0;
        end
        if (ex_reg_write && ex_rd == src) begin
            return ex_result;
        end
        if (mm_reg_write && mm_rd == src) begin
            return mm_result;
        end
        if (wb_reg_write && wb_rd == src) begin
            return wb_data;
        end
        return rf_value;
    endfunction

    // Load value not ready before writeback
    function automatic logic load_hit(input logic [reg_aw-1:0] src);
        return src != '0 && ((ex_is_load && ex_rd == src) || (mm_is_load && mm_rd == src));
    endfunction

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            f3_add_sub: return alt ? alu_sub : alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_xor:     return alu_xor;
            f3_srl:     return alu_srl;
            f3_or:      return alu_or;
            f3_and:     return alu_and;
            default:    return alu_add; // SLTU outside the subset
        endcase
    endfunction

    assign opcode = id_inst.r.opcode;
    assign funct3 = id_inst.r.funct3;
    assign rs1    = id_inst.r.rs1;
    assign rs2    = id_inst.r.rs2;
    assign rd     = id_inst.r.rd;
    assign link   = id_pc + 32'd4;

    assign imm_i = {{20{id_inst.i.imm[11]}}, id_inst.i.imm};
    assign imm_s = {{20{id_inst.s.imm_hi[6]}}, id_inst.s.imm_hi, id_inst.s.imm_lo};
    assign imm_b = {{20{id_inst.b.imm12}}, id_inst.b.imm11, id_inst.b.imm10_5,
                    id_inst.b.imm4_1, 1'b0};
    assign imm_u = {id_inst.u.imm, 12'b0};
    assign imm_j = {{12{id_inst.j.imm20}}, id_inst.j.imm19_12, id_inst.j.imm11,
                    id_inst.j.imm10_1, 1'b0};

    always_comb begin
        src_a = forward(rs1, rs1_data);
        src_b = forward(rs2, rs2_data);
    end

    always_comb begin
        op_a      = src_a;
        op_b      = src_b;
        alu_op    = alu_add;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        taken     = 1'b0;
        jump_sel  = pc_branch;
        target    = id_pc + imm_b;
        case (opcode)
            op_op: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                reg_write = 1'b1;
                alu_op    = alu_from_f3(funct3, id_inst.r.funct7 == f7_alt);
            end
            op_op_imm: begin
                use_rs1   = 1'b1;
                reg_write = 1'b1;
                op_b      = imm_i;
                alu_op    = alu_from_f3(funct3, 1'b0);
            end
            op_lui: begin
                reg_write = 1'b1;
                op_b      = imm_u;
                alu_op    = alu_pass_b;
            end
            op_load: begin
                use_rs1   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
                op_b      = imm_i;
            end
            op_store: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                mem_write = 1'b1;
                op_b      = imm_s;
            end
            op_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                taken   = (funct3 == f3_beq && src_a == src_b) ||
                          (funct3 == f3_bne && src_a != src_b);
            end
            op_jal: begin
                reg_write = 1'b1;
                op_b      = link;
                alu_op    = alu_pass_b;
                taken     = 1'b1;
                jump_sel  = pc_jal;
                target    = id_pc + imm_j;
            end
            op_jalr: begin
                use_rs1   = 1'b1;
                reg_write = 1'b1;
                op_b      = link;
                alu_op    = alu_pass_b;
                taken     = 1'b1;
                jump_sel  = pc_jalr;
                target    = (src_a + imm_i) & {{(xlen-1){1'b1}}, 1'b0};
            end
            default: ;
        endcase
    end

    assign store_data = src_b;
    assign freeze     = mem_busy;
    assign hold       = id_valid && ((use_rs1 && load_hit(rs1)) || (use_rs2 && load_hit(rs2)));
    assign issue      = id_valid && !hold;
    assign redirect   = id_valid && taken && !hold && !freeze; // Operands must be final
    assign pc_sel     = redirect ? jump_sel : pc_plus4;
    assign flush      = redirect;

    assign pipeline_stall = freeze || hold;

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       freeze,
    input  logic                       issue,
    input  logic [cpu_pkg::xlen-1:0]   op_a,
    input  logic [cpu_pkg::xlen-1:0]   op_b,
    input  logic [cpu_pkg::xlen-1:0]   store_data,
    input  cpu_pkg::alu_op_e           alu_op,
    input  logic [cpu_pkg::reg_aw-1:0] rd,
    input  logic                       reg_write,
    input  logic                       mem_read,
    input  logic                       mem_write,
    output logic [cpu_pkg::xlen-1:0]   ex_result,
    output logic [cpu_pkg::reg_aw-1:0] ex_rd,
    output logic                       ex_reg_write,
    output logic                       ex_is_load,
    output logic [cpu_pkg::xlen-1:0]   mm_result,
    output logic [cpu_pkg::xlen-1:0]   mm_store_data,
    output logic [cpu_pkg::reg_aw-1:0] mm_rd,
    output logic                       mm_reg_write,
    output logic                       mm_mem_read,
    output logic                       mm_mem_write
);
    import cpu_pkg::*;

    logic [xlen-1:0] ix_a;
    logic [xlen-1:0] ix_b;
    logic [xlen-1:0] ix_store;
    alu_op_e         ix_op;
    logic            ix_mem_write;

    // ID/EX control, bubble when nothing issues
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_reg_write <= 1'b0;
            ex_is_load   <= 1'b0;
            ix_mem_write <= 1'b0;
        end else if (!freeze) begin
            ex_reg_write <= issue && reg_write;
            ex_is_load   <= issue && mem_read;
            ix_mem_write <= issue && mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            ix_a     <= op_a;
            ix_b     <= op_b;
            ix_store <= store_data;
            ix_op    <= alu_op;
            ex_rd    <= rd;
        end
    end

    always_comb begin
        case (ix_op)
            alu_add:    ex_result = ix_a + ix_b;
            alu_sub:    ex_result = ix_a - ix_b;
            alu_and:    ex_result = ix_a & ix_b;
            alu_or:     ex_result = ix_a | ix_b;
            alu_xor:    ex_result = ix_a ^ ix_b;
            alu_slt:    ex_result = {31'b0, $signed(ix_a) < $signed(ix_b)};
            alu_sll:    ex_result = ix_a << ix_b[4:0];
            alu_srl:    ex_result = ix_a >> ix_b[4:0];
            alu_pass_b: ex_result = ix_b; // LUI and link address
            default:    ex_result = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mm_reg_write <= 1'b0;
            mm_mem_read  <= 1'b0;
            mm_mem_write <= 1'b0;
        end else if (!freeze) begin
            mm_reg_write <= ex_reg_write;
            mm_mem_read  <= ex_is_load;
            mm_mem_write <= ix_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            mm_result     <= ex_result;
            mm_store_data <= ix_store;
            mm_rd         <= ex_rd;
        end
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     freeze,
    input  logic                     hold,
    input  logic                     flush,
    input  cpu_pkg::pc_sel_e         pc_sel,
    input  logic [cpu_pkg::xlen-1:0] target,
    output logic [cpu_pkg::xlen-1:0] imem_addr,
    input  logic [cpu_pkg::xlen-1:0] imem_data,
    input  logic                     imem_ready,
    output logic [cpu_pkg::xlen-1:0] id_pc,
    output cpu_pkg::inst_u           id_inst,
    output logic                     id_valid
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic            advance;
    logic            take;

    assign imem_addr = pc;
    assign advance   = !(freeze || hold);
    assign take      = imem_ready && !flush; // Fetched word survives into decode
    assign next_pc   = (pc_sel == pc_plus4) ? pc + 32'd4 : target;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (advance && (flush || imem_ready)) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (advance) begin
            id_valid <= take;
        end
    end

    // IF/ID payload, NOP when no word is taken
    always_ff @(posedge clk) begin
        if (advance) begin
            id_pc   <= pc;
            id_inst <= take ? imem_data : nop_inst;
        end
    end

endmodule

//--- hdl/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::xlen-1:0]   mm_result,
    input  logic [cpu_pkg::xlen-1:0]   mm_store_data,
    input  logic [cpu_pkg::reg_aw-1:0] mm_rd,
    input  logic                       mm_reg_write,
    input  logic                       mm_mem_read,
    input  logic                       mm_mem_write,
    output logic [cpu_pkg::xlen-1:0]   dmem_addr,
    output logic [cpu_pkg::xlen-1:0]   dmem_write_data,
    output logic                       dmem_read,
    output logic                       dmem_write,
    input  logic [cpu_pkg::xlen-1:0]   dmem_read_data,
    input  logic                       dmem_ready,
    output logic                       mem_busy,
    output logic                       mm_is_load,
    output logic [cpu_pkg::xlen-1:0]   wb_data,
    output logic [cpu_pkg::reg_aw-1:0] wb_rd,
    output logic                       wb_reg_write
);
    import cpu_pkg::*;

    assign dmem_addr       = mm_result;
    assign dmem_write_data = mm_store_data;
    assign dmem_read       = mm_mem_read;
    assign dmem_write      = mm_mem_write;
    assign mm_is_load      = mm_mem_read;

    // Request waiting for its ready cycle
    assign mem_busy = (mm_mem_read || mm_mem_write) && !dmem_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= mm_reg_write && !mem_busy; // Bubble while frozen
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= mm_mem_read ? dmem_read_data : mm_result;
        wb_rd   <= mm_rd;
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::reg_aw-1:0] rs1,
    input  logic [cpu_pkg::reg_aw-1:0] rs2,
    output logic [cpu_pkg::xlen-1:0]   rs1_data,
    output logic [cpu_pkg::xlen-1:0]   rs2_data,
    input  logic                       we,
    input  logic [cpu_pkg::reg_aw-1:0] rd,
    input  logic [cpu_pkg::xlen-1:0]   wdata
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [reg_num]; // Entry 0 never written

    function automatic logic [xlen-1:0] read_port(input logic [reg_aw-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (we && rd == idx) begin
            return wdata; // Write-through
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < reg_num; k++) begin
                regs[k] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

//--- sim/cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     dmem_read,
    input logic                     dmem_write,
    input logic                     dmem_ready,
    input logic                     pipeline_stall,
    input logic [cpu_pkg::xlen-1:0] dmem_addr,
    input logic [cpu_pkg::xlen-1:0] dmem_write_data
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    no_read_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_read && dmem_write))
        else begin
            $error("Data read and write requested in the same cycle");
            fail_count++;
        end

    // Waiting request must not change
    request_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_read || dmem_write) && !dmem_ready |=>
        $stable(dmem_addr) && $stable(dmem_write_data) &&
        $stable(dmem_read) && $stable(dmem_write))
        else begin
            $error("Data request changed before dmem_ready");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !dmem_read && !dmem_write && !pipeline_stall)
        else begin
            $error("Request or stall seen during reset");
            fail_count++;
        end

endmodule

bind cpu_top cpu_assert u_assert (.*);

//--- sim/cpu_cases.txt
# name stall_pct n_words words(hex) n_stores then addr data pairs (hex)
# each program ends in jal x0, 0
alu_fwd 0 18
00500093 00C00113 002081B3 40118233 001242B3 00302023 00402223 00502423 00329313
00235393 1003E413 0F047493 0114A513 00A365B3 00B02623 00802823 00702A23 0000006F
6 0 11 4 C 8 9 C 49 10 112 14 12
load_use 0 10
04002083 00108113 00202023 00002183 00302223 04402203 00000013 004202B3 00502423
0000006F
3 0 5A5AA5E6 4 5A5AA5E6 8 B4B54BC2
branches 0 12
00700093 00700113 00208463 00102023 00209463 00102223 00300193 00309463 00102423
00308463 00302623 0000006F
2 4 7 C 3
jumps 0 10
00C000EF 00002023 00002223 00102023 02000113 000101E7 00002423 00002623 00302223
0000006F
2 0 4 4 18
x0_rand 40 10
00500093 06300013 00008133 00002C23 00202E23 01802183 01C02203 004182B3 02502023
0000006F
3 18 0 1C 5 20 5
alu_fwd_rand 50 18
00500093 00C00113 002081B3 40118233 001242B3 00302023 00402223 00502423 00329313
00235393 1003E413 0F047493 0114A513 00A365B3 00B02623 00802823 00702A23 0000006F
6 0 11 4 C 8 9 C 49 10 112 14 12

//--- sim/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dmem_write,
    input  logic                     dmem_ready,
    input  logic [cpu_pkg::xlen-1:0] dmem_addr,
    input  logic [cpu_pkg::xlen-1:0] dmem_write_data,
    input  logic [cpu_pkg::xlen-1:0] debug_pc,
    input  logic [cpu_pkg::xlen-1:0] debug_inst,
    input  logic [cpu_pkg::xlen-1:0] program_word,
    output int                       pending,
    output int                       errors
);
    import cpu_pkg::*;

    logic [xlen-1:0] exp_addr [$];
    logic [xlen-1:0] exp_data [$];
    string           test_name;
    int              test_errors;
    int              tests_run;
    int              tests_failed;

    initial begin
        pending      = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
    end

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        exp_addr.delete();
        exp_data.delete();
        pending = 0;
    endtask

    task automatic expect_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        pending = exp_addr.size();
    endtask

    // Completed stores only, in program order
    always @(posedge clk) begin
        if (rst_n && dmem_write && dmem_ready) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected extra store at %0t: address %h data %h", $time,
                         dmem_addr, dmem_write_data);
                count_error();
            end else begin
                if (dmem_addr !== exp_addr[0]) begin
                    $display("MISMATCH at %0t: dmem_addr expected %h got %h", $time,
                             exp_addr[0], dmem_addr);
                    count_error();
                end
                if (dmem_write_data !== exp_data[0]) begin
                    $display("MISMATCH at %0t: dmem_write_data expected %h got %h", $time,
                             exp_data[0], dmem_write_data);
                    count_error();
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                pending = exp_addr.size();
            end
        end
    end

    // Decode holds a bubble (addi x0, x0, 0) or the word stored at its PC
    always @(negedge clk) begin
        if (rst_n && debug_inst !== 32'h0000_0013 && debug_inst !== program_word) begin
            $display("MISMATCH at %0t: debug_inst expected %h got %h at pc %h", $time,
                     program_word, debug_inst, debug_pc);
            count_error();
        end
    end

    task automatic finish_test();
        if (exp_addr.size() != 0) begin
            $display("Test %s is missing %0d store(s), next expected at address %h",
                     test_name, exp_addr.size(), exp_addr[0]);
            count_error();
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d error(s)", test_name, test_errors);
        end
    endtask

    task automatic report_totals();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    endtask

endmodule

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int mem_words    = 256;
    localparam int reset_cycles = 10;
    localparam int drain_cycles = 20;   // Window for late extra stores
    localparam int cycles_per_word = 200;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        imem_ready;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_write_data;
    logic        dmem_read;
    logic        dmem_write;
    logic [31:0] dmem_read_data;
    logic        dmem_ready;
    logic [31:0] debug_pc;
    logic [31:0] debug_inst;
    logic        pipeline_stall;
    logic [31:0] program_word;

    logic [31:0] imem [mem_words];
    logic [31:0] dmem [mem_words];

    // Test table from the cases file
    string       names [$];
    int          pcts [$];
    int          word_counts [$];
    int          store_counts [$];
    logic [31:0] words [$];
    logic [31:0] store_addrs [$];
    logic [31:0] store_datas [$];

    int          seed;
    int          cur_pct;
    int          watchdog_cycles;
    bit          loaded;
    int          check_pending;
    int          check_errors;

    cpu_top uut (.*);

    cpu_checker check (
        .clk, .rst_n, .dmem_write, .dmem_ready, .dmem_addr, .dmem_write_data,
        .debug_pc, .debug_inst, .program_word,
        .pending (check_pending),
        .errors  (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction memory answers in the same cycle
    assign imem_data      = imem[imem_addr[9:2]];
    assign dmem_read_data = dmem[dmem_addr[9:2]];
    assign program_word   = imem[debug_pc[9:2]]; // Word the decode stage should hold

    always @(posedge clk) begin
        if (dmem_write && dmem_ready) begin
            dmem[dmem_addr[9:2]] = dmem_write_data;
        end
    end

    always @(posedge clk) begin
        imem_ready <= 1'b1;
        dmem_ready <= ($unsigned($random(seed)) % 100) >= cur_pct; // Stall odds in percent
    end

    // Skips comments that run from # to end of line
    task automatic read_token(input int fd, output string tok, output bit ok);
        string rest;
        int    n;
        ok = 1'b0;
        while (!ok) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                return;
            end
            if (tok.len() > 0 && tok[0] == "#") begin
                n = $fgets(rest, fd);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic load_cases(output bit opened);
        int    fd;
        int    n;
        string tok;
        bit    ok;
        fd = $fopen("sim/cpu_cases.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            read_token(fd, tok, ok);
            while (ok) begin
                names.push_back(tok);
                read_token(fd, tok, ok);
                pcts.push_back(tok.atoi());
                read_token(fd, tok, ok);
                n = tok.atoi();
                word_counts.push_back(n);
                repeat (n) begin
                    read_token(fd, tok, ok);
                    words.push_back(tok.atohex());
                end
                read_token(fd, tok, ok);
                n = tok.atoi();
                store_counts.push_back(n);
                repeat (n) begin
                    read_token(fd, tok, ok);
                    store_addrs.push_back(tok.atohex());
                    read_token(fd, tok, ok);
                    store_datas.push_back(tok.atohex());
                end
                read_token(fd, tok, ok);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t, input int word_base, input int store_base);
        int cycles;
        int limit;
        @(posedge clk);
        rst_n   <= 1'b0;
        cur_pct <= pcts[t];
        for (int k = 0; k < mem_words; k++) begin
            imem[k] = 32'h0000_006f;                // jal x0, 0
            dmem[k] = (k * 4) ^ 32'h5a5a_a5a5;      // Pattern from byte address
        end
        for (int k = 0; k < word_counts[t]; k++) begin
            imem[k] = words[word_base + k];
        end
        check.start_test(names[t]);
        for (int k = 0; k < store_counts[t]; k++) begin
            check.expect_store(store_addrs[store_base + k], store_datas[store_base + k]);
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        limit  = cycles_per_word * word_counts[t];
        cycles = 0;
        while (check_pending != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        repeat (drain_cycles) @(posedge clk);
        check.finish_test();
    endtask

    initial begin
        int word_base;
        int store_base;
        int total_words;
        bit opened;
        seed       = 32'h2604_85a0;
        rst_n      = 1'b0;
        imem_ready = 1'b1;
        dmem_ready = 1'b0;
        cur_pct    = 0;
        loaded     = 1'b0;
        load_cases(opened);
        if (!opened) begin
            $display("Could not open sim/cpu_cases.txt");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            total_words = 0;
            foreach (word_counts[t]) begin
                total_words += word_counts[t];
            end
            watchdog_cycles = cycles_per_word * total_words
                            + names.size() * (reset_cycles + drain_cycles + 10);
            loaded     = 1'b1;
            word_base  = 0;
            store_base = 0;
            for (int t = 0; t < names.size(); t++) begin
                run_test(t, word_base, store_base);
                word_base  += word_counts[t];
                store_base += store_counts[t];
            end
            check.report_totals();
            if (check_errors == 0 && uut.u_assert.fail_count == 0 && names.size() > 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

    // Global limit in case a test never returns
    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog.f
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode_ctrl.sv
hdl/exec_unit.sv
hdl/mem_wb_unit.sv
hdl/cpu_top.sv
sim/cpu_checker.sv
sim/cpu_assert.sv
sim/cpu_tb.sv
